// ==== hw/alu.sv ====
// *********************************************************
// 64-bit integer alu for the RV64I subset
// shift amount from the low six bits of b
// *********************************************************

module alu (
    input  rv_pkg::word_t   a_i,
    input  rv_pkg::word_t   b_i,
    input  rv_pkg::alu_op_e op_i,
    output rv_pkg::word_t   y_o
);

    import rv_pkg::*;

    logic [5:0] shamt;

    assign shamt = b_i[5:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  y_o = a_i + b_i;
            ALU_SUB:  y_o = a_i - b_i;
            ALU_SLL:  y_o = a_i << shamt;
            ALU_SLT:  y_o = word_t'($signed(a_i) < $signed(b_i));
            ALU_SLTU: y_o = word_t'(a_i < b_i);
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_SRL:  y_o = a_i >> shamt;
            ALU_SRA:  y_o = word_t'($signed(a_i) >>> shamt);
            ALU_OR:   y_o = a_i | b_i;
            ALU_AND:  y_o = a_i & b_i;
            // lui result comes straight from the immediate
            default:  y_o = b_i;
        endcase
    end

endmodule

// ==== hw/br_unit.sv ====
// *********************************************************
// branch condition and jump target resolution in EX
// *********************************************************

module br_unit (
    input  rv_pkg::word_t  pc_i,
    input  rv_pkg::word_t  r1_i,
    input  rv_pkg::word_t  r2_i,
    input  rv_pkg::word_t  imm_i,
    input  rv_pkg::instr_t instr_i,
    output logic           redirect_o,
    output rv_pkg::word_t  redirect_pc_o
);

    import rv_pkg::*;

    opcode_e opc;
    logic    taken;

    assign opc = opcode_e'(instr_i[6:0]);

    // funct3 selects the comparison
    always_comb begin
        case (instr_i[14:12])
            3'b000:  taken = r1_i == r2_i;
            3'b001:  taken = r1_i != r2_i;
            3'b100:  taken = $signed(r1_i) < $signed(r2_i);
            3'b101:  taken = $signed(r1_i) >= $signed(r2_i);
            3'b110:  taken = r1_i < r2_i;
            3'b111:  taken = r1_i >= r2_i;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o = (opc == OPC_JAL) || (opc == OPC_JALR) ||
                        (opc == OPC_BRANCH && taken);

    // jalr clears bit 0 of the sum
    assign redirect_pc_o = (opc == OPC_JALR) ? ((r1_i + imm_i) & ~word_t'(1))
                                             : pc_i + imm_i;

endmodule

// ==== hw/dbus_port.sv ====
// *********************************************************
// data bus requester for the MEM stage
// credit counter, in-order load response tracking
// busy while the MEM instruction cannot complete
// *********************************************************

module dbus_port #(
    parameter int DBUS_CREDITS = 2
) (
    input  logic           clk,
    input  logic           rst_n,
    input  rv_pkg::instr_t mem_instr_i,
    input  rv_pkg::word_t  addr_i,
    input  rv_pkg::word_t  wdata_i,
    output logic           dreq_valid_o,
    output logic           dreq_we_o,
    output rv_pkg::word_t  dreq_addr_o,
    output rv_pkg::word_t  dreq_wdata_o,
    input  logic           dcredit_i,
    input  rv_pkg::word_t  drsp_data_i,
    output rv_pkg::word_t  load_data_o,
    output logic           mem_busy_o
);

    import rv_pkg::*;

    localparam int CW = $clog2(DBUS_CREDITS + 1);

    logic [CW-1:0] credits;
    logic [CW-1:0] stores_ahead;
    logic          load_wait;
    logic          is_load;
    logic          is_store;
    logic          has_credit;
    logic          load_hit;

    assign is_load    = mem_instr_i[6:0] == OPC_LOAD;
    assign is_store   = mem_instr_i[6:0] == OPC_STORE;
    assign has_credit = credits != '0;

    // one request per instruction, a waiting load does not reissue
    assign dreq_valid_o = has_credit && (is_store || (is_load && !load_wait));
    assign dreq_we_o    = is_store;
    assign dreq_addr_o  = addr_i;
    assign dreq_wdata_o = wdata_i;

    // credits come back in order, earlier stores first
    assign load_hit   = load_wait && dcredit_i && (stores_ahead == '0);
    assign mem_busy_o = (is_store && !has_credit) || (is_load && !load_hit);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits      <= CW'(DBUS_CREDITS);
            load_wait    <= 1'b0;
            stores_ahead <= '0;
        end else begin
            credits <= credits - CW'(dreq_valid_o) + CW'(dcredit_i);
            if (dreq_valid_o && is_load) begin
                load_wait    <= 1'b1;
                // stores still out, less one answered this cycle
                stores_ahead <= CW'(DBUS_CREDITS) - credits - CW'(dcredit_i);
            end else if (load_hit) begin
                load_wait <= 1'b0;
            end else if (dcredit_i && stores_ahead != '0) begin
                stores_ahead <= stores_ahead - CW'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_hit) begin
            load_data_o <= drsp_data_i;
        end
    end

endmodule

// ==== hw/hart.sv ====
// *********************************************************
// rvlite hart top level, five-stage in-order pipeline
// pipeline registers, decode, immediates, operand muxes
// writeback select and the unit instances
// *********************************************************

module hart #(
    parameter rv_pkg::word_t RESET_PC     = '0,
    parameter int            DBUS_CREDITS = 2
) (
    input  logic           clk,
    input  logic           rst_n,
    output rv_pkg::word_t  imem_addr_o,
    input  rv_pkg::instr_t imem_data_i,
    output logic           dreq_valid_o,
    output logic           dreq_we_o,
    output rv_pkg::word_t  dreq_addr_o,
    output rv_pkg::word_t  dreq_wdata_o,
    input  logic           dcredit_i,
    input  rv_pkg::word_t  drsp_data_i
);

    import rv_pkg::*;

    logic     stall_if, stall_id, stall_ex, stall_mem;
    logic     flush_id, flush_ex, bubble_wb, mem_busy, redirect;
    fwd_sel_e fwd_a, fwd_b;
    word_t    pc, redirect_pc, id_pc, ex_pc;
    instr_t   id_instr, ex_instr, mem_instr, wb_instr;
    opcode_e  id_opc, ex_opc;
    alu_op_e  id_alu_op, ex_alu_op;
    word_t    id_imm, id_r1, id_r2, ex_imm, ex_r1, ex_r2;
    logic     ex_a_pc, ex_b_imm;
    word_t    opa, opb, alu_y, ex_result, mem_result, mem_wdata;
    word_t    load_data, wb_result, wb_value;
    logic     wb_wr;

    // redirect reaches the pc only once the branch leaves EX
    pc_unit #(.RESET_PC(RESET_PC)) pc_unit_inst (
        .clk(clk), .rst_n(rst_n), .stall_i(stall_if), .redirect_i(redirect && !stall_ex),
        .redirect_pc_i(redirect_pc), .pc_o(pc)
    );

    assign imem_addr_o = pc;

    always_ff @(posedge clk) begin
        if (!rst_n || flush_id) begin
            id_instr <= NOP_INSTR;
        end else if (!stall_id) begin
            id_instr <= imem_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_id) begin
            id_pc <= pc;
        end
    end

    // ID
    assign id_opc = opcode_e'(id_instr[6:0]);

    regfile regfile_inst (
        .clk(clk), .rs1_i(id_instr[19:15]), .rs2_i(id_instr[24:20]), .rd_i(wb_instr[11:7]),
        .wr_i(wb_wr), .d_i(wb_value), .r1_o(id_r1), .r2_o(id_r2)
    );

    always_comb begin
        case (id_opc)
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: id_imm = {{52{id_instr[31]}}, id_instr[31:20]};
            OPC_STORE: id_imm = {{52{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
            OPC_LUI, OPC_AUIPC: id_imm = {{32{id_instr[31]}}, id_instr[31:12], 12'b0};
            OPC_BRANCH: id_imm = {{52{id_instr[31]}}, id_instr[7], id_instr[30:25],
                                  id_instr[11:8], 1'b0};
            OPC_JAL: id_imm = {{44{id_instr[31]}}, id_instr[19:12], id_instr[20],
                               id_instr[30:21], 1'b0};
            default: id_imm = '0;
        endcase
    end

    // OP and OP-IMM share funct3, sub only exists in OP
    always_comb begin
        id_alu_op = ALU_ADD;
        if (id_opc == OPC_LUI) begin
            id_alu_op = ALU_PASS_B;
        end else if (id_opc == OPC_OP || id_opc == OPC_OP_IMM) begin
            case (id_instr[14:12])
                3'b000:  id_alu_op = (id_opc == OPC_OP && id_instr[30]) ? ALU_SUB : ALU_ADD;
                3'b001:  id_alu_op = ALU_SLL;
                3'b010:  id_alu_op = ALU_SLT;
                3'b011:  id_alu_op = ALU_SLTU;
                3'b100:  id_alu_op = ALU_XOR;
                3'b101:  id_alu_op = id_instr[30] ? ALU_SRA : ALU_SRL;
                3'b110:  id_alu_op = ALU_OR;
                default: id_alu_op = ALU_AND;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_ex) begin
            ex_instr <= NOP_INSTR;
        end else if (!stall_ex) begin
            ex_instr <= id_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_ex) begin
            ex_pc     <= id_pc;
            ex_r1     <= id_r1;
            ex_r2     <= id_r2;
            ex_imm    <= id_imm;
            ex_alu_op <= id_alu_op;
            ex_a_pc   <= id_opc == OPC_AUIPC;
            ex_b_imm  <= !(id_opc inside {OPC_OP, OPC_BRANCH});
        end else begin
            // WB drains while EX waits, so keep the forwarded values
            ex_r1 <= opa;
            ex_r2 <= opb;
        end
    end

    // EX
    assign ex_opc = opcode_e'(ex_instr[6:0]);

    always_comb begin
        case (fwd_a)
            FWD_MEM: opa = mem_result;
            FWD_WB:  opa = wb_value;
            default: opa = ex_r1;
        endcase
        case (fwd_b)
            FWD_MEM: opb = mem_result;
            FWD_WB:  opb = wb_value;
            default: opb = ex_r2;
        endcase
    end

    alu alu_inst (
        .a_i(ex_a_pc ? ex_pc : opa), .b_i(ex_b_imm ? ex_imm : opb),
        .op_i(ex_alu_op), .y_o(alu_y)
    );

    br_unit br_unit_inst (
        .pc_i(ex_pc), .r1_i(opa), .r2_i(opb), .imm_i(ex_imm), .instr_i(ex_instr),
        .redirect_o(redirect), .redirect_pc_o(redirect_pc)
    );

    // jumps link pc+4, also what MEM forwards
    assign ex_result = (ex_opc == OPC_JAL || ex_opc == OPC_JALR) ? ex_pc + word_t'(4) : alu_y;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_instr <= NOP_INSTR;
        end else if (!stall_mem) begin
            mem_instr <= ex_instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_mem) begin
            mem_result <= ex_result;
            mem_wdata  <= opb;
        end
    end

    // MEM
    dbus_port #(.DBUS_CREDITS(DBUS_CREDITS)) dbus_port_inst (
        .clk(clk), .rst_n(rst_n), .mem_instr_i(mem_instr), .addr_i(mem_result),
        .wdata_i(mem_wdata), .dreq_valid_o(dreq_valid_o), .dreq_we_o(dreq_we_o),
        .dreq_addr_o(dreq_addr_o), .dreq_wdata_o(dreq_wdata_o), .dcredit_i(dcredit_i),
        .drsp_data_i(drsp_data_i), .load_data_o(load_data), .mem_busy_o(mem_busy)
    );

    always_ff @(posedge clk) begin
        if (!rst_n || bubble_wb) begin
            wb_instr <= NOP_INSTR;
        end else begin
            wb_instr <= mem_instr;
        end
    end

    always_ff @(posedge clk) begin
        wb_result <= mem_result;
    end

    // WB
    assign wb_value = (wb_instr[6:0] == OPC_LOAD) ? load_data : wb_result;
    assign wb_wr    = !(wb_instr[6:0] inside {OPC_BRANCH, OPC_STORE});

    hazard_unit hazard_unit_inst (
        .id_instr_i(id_instr), .ex_instr_i(ex_instr), .mem_instr_i(mem_instr),
        .wb_instr_i(wb_instr), .redirect_i(redirect), .mem_busy_i(mem_busy),
        .stall_if_o(stall_if), .stall_id_o(stall_id), .stall_ex_o(stall_ex),
        .stall_mem_o(stall_mem), .flush_id_o(flush_id), .flush_ex_o(flush_ex),
        .bubble_wb_o(bubble_wb), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b)
    );

endmodule

// ==== hw/hazard_unit.sv ====
// *********************************************************
// operand forwarding selects for EX
// load-use detection, stage stalls and flushes
// *********************************************************

module hazard_unit (
    input  rv_pkg::instr_t   id_instr_i,
    input  rv_pkg::instr_t   ex_instr_i,
    input  rv_pkg::instr_t   mem_instr_i,
    input  rv_pkg::instr_t   wb_instr_i,
    input  logic             redirect_i,
    input  logic             mem_busy_i,
    output logic             stall_if_o,
    output logic             stall_id_o,
    output logic             stall_ex_o,
    output logic             stall_mem_o,
    output logic             flush_id_o,
    output logic             flush_ex_o,
    output logic             bubble_wb_o,
    output rv_pkg::fwd_sel_e fwd_a_o,
    output rv_pkg::fwd_sel_e fwd_b_o
);

    import rv_pkg::*;

    logic load_use;

    function automatic logic writes_rd(instr_t ins);
        opcode_e opc;
        opc = opcode_e'(ins[6:0]);
        return (ins[11:7] != 5'd0) && (opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL,
                                                   OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP});
    endfunction

    function automatic logic uses_rs1(instr_t ins);
        return !(ins[6:0] inside {OPC_LUI, OPC_AUIPC, OPC_JAL});
    endfunction

    function automatic logic uses_rs2(instr_t ins);
        return ins[6:0] inside {OPC_OP, OPC_BRANCH, OPC_STORE};
    endfunction

    // the younger producer in MEM wins over WB
    function automatic fwd_sel_e pick(reg_idx_t rs);
        if (writes_rd(mem_instr_i) && mem_instr_i[11:7] == rs) begin
            return FWD_MEM;
        end
        if (writes_rd(wb_instr_i) && wb_instr_i[11:7] == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd_a_o = pick(ex_instr_i[19:15]);
    assign fwd_b_o = pick(ex_instr_i[24:20]);

    // load data only exists from WB on
    assign load_use = (ex_instr_i[6:0] == OPC_LOAD) && writes_rd(ex_instr_i) &&
                      ((uses_rs1(id_instr_i) && id_instr_i[19:15] == ex_instr_i[11:7]) ||
                       (uses_rs2(id_instr_i) && id_instr_i[24:20] == ex_instr_i[11:7]));

    assign stall_if_o  = mem_busy_i || load_use;
    assign stall_id_o  = mem_busy_i || load_use;
    assign stall_ex_o  = mem_busy_i;
    assign stall_mem_o = mem_busy_i;

    // a branch held in EX must not kill itself
    assign flush_id_o  = redirect_i && !mem_busy_i;
    assign flush_ex_o  = (redirect_i || load_use) && !mem_busy_i;
    assign bubble_wb_o = mem_busy_i;

endmodule

// ==== hw/pc_unit.sv ====
// *********************************************************
// program counter with redirect and stall
// *********************************************************

module pc_unit #(
    parameter rv_pkg::word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall_i,
    input  logic          redirect_i,
    input  rv_pkg::word_t redirect_pc_i,
    output rv_pkg::word_t pc_o
);

    import rv_pkg::*;

    word_t pc;

    // redirect wins over a stall
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (redirect_i) begin
            pc <= redirect_pc_i;
        end else if (!stall_i) begin
            pc <= pc + word_t'(4);
        end
    end

    assign pc_o = pc;

endmodule

// ==== hw/regfile.sv ====
// *********************************************************
// 32 x 64 register file, two read ports, one write port
// x0 reads zero, same-cycle write is visible on read
// *********************************************************

module regfile (
    input  logic             clk,
    input  rv_pkg::reg_idx_t rs1_i,
    input  rv_pkg::reg_idx_t rs2_i,
    input  rv_pkg::reg_idx_t rd_i,
    input  logic             wr_i,
    input  rv_pkg::word_t    d_i,
    output rv_pkg::word_t    r1_o,
    output rv_pkg::word_t    r2_o
);

    import rv_pkg::*;

    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (wr_i && rd_i != '0) begin
            regs[rd_i] <= d_i;
        end
    end

    // write-through so WB needs no path back into ID
    function automatic word_t read_port(reg_idx_t rs);
        if (rs == '0) begin
            return '0;
        end
        if (wr_i && rs == rd_i) begin
            return d_i;
        end
        return regs[rs];
    endfunction

    assign r1_o = read_port(rs1_i);
    assign r2_o = read_port(rs2_i);

endmodule

// ==== hw/rv_pkg.sv ====
// *********************************************************
// shared widths and types for the rvlite hart
// opcode, alu operation and forwarding select encodings
// bubble instruction used by the pipeline registers
// *********************************************************

package rv_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;

    // base opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // operand source for EX
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // addi x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the hart testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -j 0 -f rvlite.f --top-module hart_tb -o hart_sim || exit 1
./obj_dir/hart_sim > sim.log 2>&1
cat sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== rvlite.f ====
+incdir+include
hw/rv_pkg.sv
hw/pc_unit.sv
hw/regfile.sv
hw/alu.sv
hw/br_unit.sv
hw/hazard_unit.sv
hw/dbus_port.sv
hw/hart.sv
tests/hart_tb.sv

// ==== include/tb_asm.svh ====
// *********************************************************
// instruction encoders for the rvlite subset
// base formats plus a few common shorthands
// *********************************************************

`ifndef TB_ASM_SVH
`define TB_ASM_SVH

function automatic rv_pkg::instr_t asm_r(logic [6:0] f7, rv_pkg::reg_idx_t rs2,
                                         rv_pkg::reg_idx_t rs1, logic [2:0] f3,
                                         rv_pkg::reg_idx_t rd, rv_pkg::opcode_e opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

// also covers shifts, f7 goes in the top immediate bits
function automatic rv_pkg::instr_t asm_i(int imm, rv_pkg::reg_idx_t rs1, logic [2:0] f3,
                                         rv_pkg::reg_idx_t rd, rv_pkg::opcode_e opc);
    return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic rv_pkg::instr_t asm_sd(int off, rv_pkg::reg_idx_t rs2, rv_pkg::reg_idx_t rs1);
    return {off[11:5], rs2, rs1, 3'b011, off[4:0], rv_pkg::OPC_STORE};
endfunction

function automatic rv_pkg::instr_t asm_ld(int off, rv_pkg::reg_idx_t rs1, rv_pkg::reg_idx_t rd);
    return asm_i(off, rs1, 3'b011, rd, rv_pkg::OPC_LOAD);
endfunction

// byte offset relative to the branch
function automatic rv_pkg::instr_t asm_b(int off, rv_pkg::reg_idx_t rs2,
                                         rv_pkg::reg_idx_t rs1, logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::OPC_BRANCH};
endfunction

function automatic rv_pkg::instr_t asm_u(logic [19:0] imm, rv_pkg::reg_idx_t rd,
                                         rv_pkg::opcode_e opc);
    return {imm, rd, opc};
endfunction

function automatic rv_pkg::instr_t asm_jal(int off, rv_pkg::reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::OPC_JAL};
endfunction

`endif

// ==== tests/hart_tb.sv ====
// *********************************************************
// testbench for the rvlite hart
// clock, instruction and data memory models with credits
// directed program tests, compare tasks, cycle timeout
// *********************************************************

module hart_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rv_pkg::*;

    `include "tb_asm.svh"

    localparam int DBUS_CREDITS = 2;
    // program lengths times worst credit delay, with margin
    localparam int MAX_CYCLES = 4000;

    logic   clk;
    logic   rst_n;
    word_t  imem_addr_o;
    instr_t imem_data_i;
    logic   dreq_valid_o;
    logic   dreq_we_o;
    word_t  dreq_addr_o;
    word_t  dreq_wdata_o;
    logic   dcredit_i;
    word_t  drsp_data_i;

    instr_t imem [256];
    word_t  dmem [word_t];
    instr_t prog [$];
    word_t  exp_addr [$];
    word_t  exp_data [$];
    word_t  st_addr [$];
    word_t  st_data [$];
    int     due_q [$];
    logic   pend_we [$];
    word_t  pend_addr [$];
    word_t  rng = 64'd98;
    int     cycle = 0;
    int     due;
    int     slot;
    int     err_cnt = 0;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    logic   done = 1'b0;

    hart #(.RESET_PC('0), .DBUS_CREDITS(DBUS_CREDITS)) hart_inst (
        .clk(clk), .rst_n(rst_n), .imem_addr_o(imem_addr_o), .imem_data_i(imem_data_i),
        .dreq_valid_o(dreq_valid_o), .dreq_we_o(dreq_we_o), .dreq_addr_o(dreq_addr_o),
        .dreq_wdata_o(dreq_wdata_o), .dcredit_i(dcredit_i), .drsp_data_i(drsp_data_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // tightly coupled instruction memory
    assign imem_data_i = imem[imem_addr_o[9:2]];

    function word_t xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 7);
        rng = rng ^ (rng << 17);
        return rng;
    endfunction

    // requests are taken mid cycle, where the bus is settled
    always @(negedge clk) begin
        if (rst_n && dreq_valid_o) begin
            if (dreq_we_o) begin
                dmem[dreq_addr_o] = dreq_wdata_o;
                st_addr.push_back(dreq_addr_o);
                st_data.push_back(dreq_wdata_o);
                if (dreq_addr_o == 64'h1000) begin
                    done = 1'b1;
                end
            end
            due = cycle + 1 + int'(xorshift() % 64'd4);
            // credits return in request order
            if (due_q.size() > 0 && due <= due_q[$]) begin
                due = due_q[$] + 1;
            end
            due_q.push_back(due);
            pend_we.push_back(dreq_we_o);
            pend_addr.push_back(dreq_addr_o);
            if (due_q.size() > DBUS_CREDITS) begin
                $display("more than %0d data requests outstanding at cycle %0d",
                         DBUS_CREDITS, cycle);
                err_cnt++;
            end
        end
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > MAX_CYCLES) begin
            $display("timeout after %0d cycles, the run did not complete", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end else begin
            #2;
            dcredit_i = 1'b0;
            if (rst_n && due_q.size() > 0 && due_q[0] <= cycle) begin
                dcredit_i = 1'b1;
                if (pend_we[0]) begin
                    drsp_data_i = '0;
                end else if (dmem.exists(pend_addr[0])) begin
                    drsp_data_i = dmem[pend_addr[0]];
                end else begin
                    drsp_data_i = ~pend_addr[0];
                end
                void'(due_q.pop_front());
                void'(pend_we.pop_front());
                void'(pend_addr.pop_front());
            end
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_addr(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            err_cnt++;
        end
    endtask

    // RV64I integer results, alt selects sub and sra
    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[5:0];
            3'd2:    return {63'd0, $signed(a) < $signed(b)};
            3'd3:    return {63'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic word_t pc_now();
        return word_t'(longint'(prog.size()) * 4);
    endfunction

    task automatic emit(input instr_t ins);
        prog.push_back(ins);
    endtask

    // x28 data base 0x400, x31 result base 0x200, x30 end marker 0x1000
    task automatic begin_prog();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        slot = 0;
        emit(asm_i(1024, 5'd0, 3'b000, 5'd28, OPC_OP_IMM));
        emit(asm_i(512, 5'd0, 3'b000, 5'd31, OPC_OP_IMM));
        emit(asm_u(20'd1, 5'd30, OPC_LUI));
    endtask

    task automatic save(input reg_idx_t r, input word_t v);
        emit(asm_sd(slot * 8, r, 5'd31));
        exp_addr.push_back(word_t'(longint'(512 + slot * 8)));
        exp_data.push_back(v);
        slot++;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        rst_n = 1'b0;
        @(negedge clk);
        due_q.delete();
        pend_we.delete();
        pend_addr.delete();
        st_addr.delete();
        st_data.delete();
        done = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    task automatic run_prog(input string name);
        int errs;
        int n;
        errs = err_cnt;
        emit(asm_sd(0, 5'd0, 5'd30));
        exp_addr.push_back(64'h1000);
        exp_data.push_back('0);
        // unused words are harmless addi x0 carrying their index
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : asm_i(i, 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
        end
        apply_reset();
        while (!done) begin
            @(posedge clk);
        end
        if (st_addr.size() != exp_addr.size()) begin
            $display("%s: expected %0d stores but the hart made %0d",
                     name, exp_addr.size(), st_addr.size());
            err_cnt++;
        end
        n = (st_addr.size() < exp_addr.size()) ? st_addr.size() : exp_addr.size();
        for (int i = 0; i < n; i++) begin
            check_addr("dreq_addr_o", st_addr[i], exp_addr[i]);
            check_word("dreq_wdata_o", st_data[i], exp_data[i]);
        end
        if (err_cnt == errs) begin
            pass_cnt++;
            $display("test %s passed", name);
        end else begin
            fail_cnt++;
            $display("test %s failed", name);
        end
    endtask

    task automatic test_alu();
        word_t       a;
        word_t       b;
        word_t       r;
        int          imm;
        logic [2:0]  f3;
        logic [19:0] u;
        begin_prog();
        a = xorshift();
        b = xorshift();
        dmem[64'h400] = a;
        dmem[64'h408] = b;
        emit(asm_ld(0, 5'd28, 5'd1));
        emit(asm_ld(8, 5'd28, 5'd2));
        // eight funct3 codes, then sub and sra
        for (int k = 0; k < 10; k++) begin
            f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            emit(asm_r((k < 8) ? 7'h00 : 7'h20, 5'd2, 5'd1, f3, 5'd3, OPC_OP));
            save(5'd3, alu_ref(f3, k >= 8, a, b));
        end
        for (int k = 0; k < 9; k++) begin
            f3 = (k < 8) ? 3'(k) : 3'd5;
            r = xorshift();
            imm = int'($signed(r[11:0]));
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = int'(r[5:0]) + ((k == 8) ? 1024 : 0);
            end
            emit(asm_i(imm, 5'd1, f3, 5'd3, OPC_OP_IMM));
            save(5'd3, alu_ref(f3, k == 8, a, word_t'(longint'(imm))));
        end
        r = xorshift();
        u = r[19:0];
        emit(asm_u(u, 5'd3, OPC_LUI));
        save(5'd3, word_t'(longint'($signed({u, 12'h000}))));
        r = xorshift();
        u = r[39:20];
        r = pc_now();
        emit(asm_u(u, 5'd3, OPC_AUIPC));
        save(5'd3, r + word_t'(longint'($signed({u, 12'h000}))));
        run_prog("alu");
    endtask

    task automatic test_forward();
        word_t a;
        word_t x2;
        word_t x3;
        word_t x4;
        word_t x5;
        begin_prog();
        a = xorshift();
        dmem[64'h400] = a;
        emit(asm_ld(0, 5'd28, 5'd1));
        emit(asm_i(5, 5'd1, 3'b000, 5'd2, OPC_OP_IMM));
        emit(asm_r(7'h00, 5'd1, 5'd2, 3'b100, 5'd3, OPC_OP));
        emit(asm_r(7'h00, 5'd3, 5'd2, 3'b000, 5'd4, OPC_OP));
        // x2 now three back, x4 one back
        emit(asm_r(7'h20, 5'd2, 5'd4, 3'b000, 5'd5, OPC_OP));
        emit(asm_r(7'h00, 5'd5, 5'd3, 3'b110, 5'd6, OPC_OP));
        x2 = a + 64'd5;
        x3 = x2 ^ a;
        x4 = x2 + x3;
        x5 = x4 - x2;
        save(5'd2, x2);
        save(5'd3, x3);
        save(5'd4, x4);
        save(5'd5, x5);
        save(5'd6, x3 | x5);
        run_prog("forwarding");
    endtask

    task automatic test_load_use();
        word_t a;
        word_t b;
        begin_prog();
        a = xorshift();
        b = xorshift();
        dmem[64'h400] = a;
        dmem[64'h408] = b;
        emit(asm_ld(0, 5'd28, 5'd1));
        save(5'd1, a);
        // read back what was just stored, then use it at once
        emit(asm_ld(0, 5'd31, 5'd2));
        emit(asm_r(7'h00, 5'd1, 5'd2, 3'b000, 5'd3, OPC_OP));
        save(5'd3, a + a);
        emit(asm_ld(8, 5'd28, 5'd4));
        emit(asm_r(7'h00, 5'd4, 5'd4, 3'b000, 5'd5, OPC_OP));
        save(5'd5, b + b);
        run_prog("load_use");
    endtask

    task automatic test_control();
        word_t      a;
        word_t      b;
        word_t      p;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] f3;
        begin_prog();
        // signed and unsigned order disagree on this pair
        a = xorshift() | 64'h8000_0000_0000_0000;
        b = xorshift() & 64'h7fff_ffff_ffff_ffff;
        dmem[64'h400] = a;
        dmem[64'h408] = b;
        emit(asm_ld(0, 5'd28, 5'd1));
        emit(asm_ld(8, 5'd28, 5'd2));
        emit(asm_i(-1, 5'd0, 3'b000, 5'd9, OPC_OP_IMM));
        for (int q = 0; q < 3; q++) begin
            rs1 = (q == 1) ? 5'd2 : 5'd1;
            rs2 = (q == 0) ? 5'd2 : 5'd1;
            for (int j = 0; j < 6; j++) begin
                f3 = (j < 2) ? 3'(j) : 3'(j + 2);
                emit(asm_i(0, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
                emit(asm_b(8, rs2, rs1, f3));
                emit(asm_i(1, 5'd0, 3'b000, 5'd7, OPC_OP_IMM));
                save(5'd7, branch_taken(f3, (rs1 == 5'd1) ? a : b,
                                        (rs2 == 5'd1) ? a : b) ? 64'd0 : 64'd1);
            end
        end
        p = pc_now();
        emit(asm_jal(12, 5'd5));
        emit(asm_sd(2000, 5'd9, 5'd31));
        emit(asm_sd(2000, 5'd9, 5'd31));
        save(5'd5, p + 64'd4);
        p = pc_now();
        emit(asm_u(20'd0, 5'd6, OPC_AUIPC));
        emit(asm_i(16, 5'd6, 3'b000, 5'd8, OPC_JALR));
        emit(asm_sd(2000, 5'd9, 5'd31));
        emit(asm_sd(2000, 5'd9, 5'd31));
        save(5'd8, p + 64'd8);
        run_prog("control_flow");
    endtask

    task automatic test_backpressure();
        word_t vals [11];
        begin_prog();
        for (int i = 1; i <= 10; i++) begin
            vals[i] = xorshift();
            dmem[word_t'(longint'(1024 + i * 8))] = vals[i];
            emit(asm_ld(i * 8, 5'd28, 5'(i)));
        end
        // ten back to back stores against two credits
        for (int i = 1; i <= 10; i++) begin
            save(5'(i), vals[i]);
        end
        run_prog("credit_backpressure");
    endtask

    initial begin
        rst_n = 1'b0;
        dcredit_i = 1'b0;
        drsp_data_i = '0;
        test_alu();
        test_forward();
        test_load_use();
        test_control();
        test_backpressure();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
